//--- flist.f
+incdir+.
dazzler_pkg.sv
io_ctrl.sv
spi_engine.sv
wii_pad_regs.sv
audio_integrator.sv
dazzler_io_top.sv
tb_dazzler_io.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/100ps
TOP       := tb_dazzler_io
FLIST     := flist.f
LOG       := sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "TB PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- tb_dazzler_model.svh
`ifndef TB_DAZZLER_MODEL_SVH
`define TB_DAZZLER_MODEL_SVH

// 32-bit lcg with the upper half as the random word
function automatic dazzler_pkg::io_word_t next_rand();
  lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
  return lcg_state[31:16];
endfunction

// six decoded bytes with lx at the bottom and rt on top
function automatic logic [47:0] pad_decode(input dazzler_pkg::wii_raw_t raw);
  logic [7:0] f [6];
  f[0] = {2'b00, raw[5:0]};                         // lx
  f[1] = {2'b00, raw[13:8]};                        // ly
  f[2] = {3'b000, raw[7:6], raw[15:14], raw[23]};   // rx spread over three raw bytes
  f[3] = {3'b000, raw[20:16]};                      // ry
  f[4] = {3'b000, raw[22:21], raw[31:29]};          // lt
  f[5] = {3'b000, raw[28:24]};                      // rt
  return {f[5], f[4], f[3], f[2], f[1], f[0]};
endfunction

// pin register as read back with live miso forcing bit 1
function automatic dazzler_pkg::io_word_t pin_read(input dazzler_pkg::io_word_t wd,
                                                   input logic miso);
  dazzler_pkg::io_word_t rd;
  rd = wd & 16'h003f;  // only six pin bits are stored
  if (miso) begin
    rd[1] = 1'b1;
  end
  return rd;
endfunction

// one full window at a constant audio level
function automatic dazzler_pkg::io_word_t window_sample(input logic level);
  int sum;
  sum = `DAZ_INT_WINDOW * `DAZ_INT_WEIGHT;
  return level ? 16'(sum) : 16'(-sum);
endfunction

`endif

//--- tb_dazzler_io.sv
`default_nettype none

`include "dazzler_config.svh"

module tb_dazzler_io;

  timeunit 1ns;
  timeprecision 100ps;

  logic                  clk50;
  logic                  SCKclock;
  dazzler_pkg::io_addr_t io_a_i;
  dazzler_pkg::io_word_t io_wd_i;
  logic                  io_w_i;
  logic                  audio_i;
  logic                  miso_i;
  dazzler_pkg::io_word_t io_rd_o;
  logic                  cs_o;
  logic                  sck_o;
  logic                  mosi_o;
  logic                  io2_o;
  logic                  io3_o;
  logic                  pd_o;

  logic [31:0] lcg_state;
  int          err_cnt = 0;
  int          chk_cnt = 0;

`include "tb_dazzler_model.svh"

  dazzler_io_top i_dut (.*);

  initial begin
    clk50 = 1'b0;
    forever #4 clk50 = ~clk50;
  end

  task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic bus_write(input dazzler_pkg::io_addr_t a, input dazzler_pkg::io_word_t d);
    @(posedge clk50);
    #1;
    io_a_i  = a;
    io_wd_i = d;
    io_w_i  = 1'b1;
    @(posedge clk50);  // write lands here
    #1;
    io_w_i = 1'b0;
  endtask

  task automatic bus_read(input dazzler_pkg::io_addr_t a, output dazzler_pkg::io_word_t d);
    @(posedge clk50);
    #1;
    io_a_i = a;
    #1;
    d = io_rd_o;
  endtask

  task automatic read_check(input string name, input dazzler_pkg::io_addr_t a,
                            input dazzler_pkg::io_word_t exp);
    dazzler_pkg::io_word_t d;
    bus_read(a, d);
    check_eq(name, d, exp);
  endtask

  task automatic report(input string name, input int err0);
    $display("%-14s finished, %0d errors", name, err_cnt - err0);
  endtask

  ////////////////////////////////////////
  // tests
  ////////////////////////////////////////

  task automatic reset_values();
    int          err0;
    logic [47:0] rst;
    err0 = err_cnt;
    rst  = `DAZ_WII_RESET;
    check_eq("pd_o", pd_o, 0);
    check_eq("cs_o", cs_o, 0);
    read_check("sysctl", `DAZ_ADDR_SYSCTL, 16'h0000);
    read_check("spi_data", `DAZ_ADDR_SPI_DATA, 16'h0000);
    read_check("sample", `DAZ_ADDR_SAMPLE, 16'h0000);
    read_check("spi_idle", `DAZ_ADDR_SPI_IDLE, 16'h0001);
    for (int s = 0; s < 3; s++) begin
      read_check("wii1_raw", `DAZ_ADDR_WII1_0 + 12'(s), rst[s*16 +: 16]);
      read_check("wii2_raw", `DAZ_ADDR_WII2_0 + 12'(s), rst[s*16 +: 16]);
    end
    report("reset_values", err0);
  endtask

  task automatic register_bank();
    int                    err0;
    int                    k;
    dazzler_pkg::io_word_t wd;
    dazzler_pkg::io_word_t rnd;
    dazzler_pkg::io_word_t t0;
    dazzler_pkg::io_word_t t1;
    err0 = err_cnt;
    for (int n = 0; n < 8; n++) begin
      wd = next_rand();
      bus_write(`DAZ_ADDR_SYSCTL, wd);
      read_check("sysctl", `DAZ_ADDR_SYSCTL, wd);
      check_eq("pd_o", pd_o, wd[0]);
      wd = next_rand();
      bus_write(`DAZ_ADDR_CSPI, wd);
      rnd    = next_rand();
      miso_i = rnd[15];  // live miso level seen on bit 1
      read_check("cspi", `DAZ_ADDR_CSPI, pin_read(wd, miso_i));
      check_eq("cs_o", cs_o, wd[5]);
      check_eq("io3_o", io3_o, wd[3]);
      check_eq("io2_o", io2_o, wd[2]);
    end
    k = 2 + int'(next_rand() % 16'd20);
    bus_read(`DAZ_ADDR_TICKS, t0);
    repeat (k - 1) @(posedge clk50);
    bus_read(`DAZ_ADDR_TICKS, t1);
    check_eq("ticks", 16'(t1 - t0), 16'(k));
    report("register_bank", err0);
  endtask

  task automatic pad_registers();
    int                    err0;
    dazzler_pkg::wii_raw_t raw [2];
    logic [47:0]           dec;
    err0 = err_cnt;
    for (int n = 0; n < 2; n++) begin
      for (int p = 0; p < 2; p++) begin
        for (int s = 0; s < 3; s++) begin
          raw[p][s*16 +: 16] = next_rand();
          bus_write(`DAZ_ADDR_WII1_0 + 12'(3 * p + s), raw[p][s*16 +: 16]);
        end
      end
      for (int p = 0; p < 2; p++) begin
        dec = pad_decode(raw[p]);
        for (int s = 0; s < 3; s++) begin
          read_check($sformatf("wii%0d_raw", p + 1), `DAZ_ADDR_WII1_0 + 12'(3 * p + s),
                     raw[p][s*16 +: 16]);
          read_check($sformatf("wii%0d_dec", p + 1), `DAZ_ADDR_WII1_DEC_0 + 12'(3 * p + s),
                     dec[s*16 +: 16]);
        end
      end
    end
    report("pad_registers", err0);
  endtask

  task automatic spi_transfers();
    int                    err0;
    int                    nbits;
    int                    rises;
    int                    cycles;
    logic                  sck_prev;
    logic                  done;
    dazzler_pkg::io_word_t tx;
    dazzler_pkg::io_word_t reply;
    err0 = err_cnt;
    bus_write(`DAZ_ADDR_CSPI, 16'h0000);  // manual sck and mosi low
    for (int n = 0; n < 4; n++) begin
      tx       = next_rand();
      reply    = next_rand();
      nbits    = 0;
      rises    = 0;
      cycles   = 0;
      sck_prev = 1'b0;
      done     = 1'b0;
      bus_write(`DAZ_ADDR_SPI_DATA, tx);
      io_a_i = `DAZ_ADDR_SPI_IDLE;
      while (!done && cycles < 40) begin
        if (!sck_o && nbits < 16) begin
          miso_i = reply[15 - nbits];  // slave shifts while sck is low
          nbits++;
        end
        #1;
        if (sck_o && !sck_prev) begin
          if (rises < 16) check_eq("mosi_o", mosi_o, tx[15 - rises]);
          rises++;
        end
        sck_prev = sck_o;
        done     = io_rd_o[0];
        if (!done) begin
          @(posedge clk50);
          #1;
          cycles++;
        end
      end
      if (!done) begin
        err_cnt++;
        $display("spi transfer did not return to idle within 40 cycles");
      end
      check_eq("sck_o rises", rises, 16);
      read_check("spi_data", `DAZ_ADDR_SPI_DATA, reply);
    end
    report("spi_transfers", err0);
  endtask

  // returns once a window closes and the read-back sample moves
  task automatic wait_sample_change();
    dazzler_pkg::io_word_t prev;
    int                    cycles;
    @(posedge clk50);
    #1;
    io_a_i = `DAZ_ADDR_SAMPLE;
    #1;
    prev   = io_rd_o;
    cycles = 0;
    while (io_rd_o === prev && cycles < 3200) begin
      @(posedge clk50);
      #2;
      cycles++;
    end
    if (io_rd_o === prev) begin
      err_cnt++;
      $display("audio sample did not change within 3200 cycles");
    end
  endtask

  task automatic audio_windows();
    int err0;
    err0 = err_cnt;
    @(posedge clk50);
    #1;
    audio_i = 1'b1;
    wait_sample_change();  // mixed window
    wait_sample_change();
    read_check("sample", `DAZ_ADDR_SAMPLE, window_sample(1'b1));
    @(posedge clk50);
    #1;
    audio_i = 1'b0;
    wait_sample_change();
    wait_sample_change();
    read_check("sample", `DAZ_ADDR_SAMPLE, window_sample(1'b0));
    report("audio_windows", err0);
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial begin
    lcg_state = 32'd65;
    SCKclock  = 1'b1;
    io_a_i    = '0;
    io_wd_i   = '0;
    io_w_i    = 1'b0;
    audio_i   = 1'b0;
    miso_i    = 1'b0;
    repeat (8) @(posedge clk50);
    #1;
    SCKclock = 1'b0;
    reset_values();
    register_bank();
    pad_registers();
    spi_transfers();
    audio_windows();
    $display("tests 5, checks %0d, errors %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- dazzler_io_top.sv
`default_nettype none

module dazzler_io_top (
  input  logic                  clk50,
  input  logic                  SCKclock,
  input  dazzler_pkg::io_addr_t io_a_i,
  input  dazzler_pkg::io_word_t io_wd_i,
  input  logic                  io_w_i,
  input  logic                  audio_i,
  input  logic                  miso_i,
  output dazzler_pkg::io_word_t io_rd_o,
  output logic                  cs_o,
  output logic                  sck_o,
  output logic                  mosi_o,
  output logic                  io2_o,
  output logic                  io3_o,
  output logic                  pd_o
);

  logic                   spi_start;
  logic [5:0]             wii_wr;
  dazzler_pkg::spi_pins_t spi_pins;
  dazzler_pkg::io_word_t  spi_rx;
  logic                   spi_idle;
  dazzler_pkg::wii_raw_t  wii1_raw;
  dazzler_pkg::wii_raw_t  wii2_raw;
  dazzler_pkg::wii_dec_t  wii1_dec;
  dazzler_pkg::wii_dec_t  wii2_dec;
  dazzler_pkg::sample_t   sample;

  ////////////////////////////////////////
  // control
  ////////////////////////////////////////

  io_ctrl i_ctrl (
    .clk50       (clk50),
    .SCKclock    (SCKclock),
    .io_a_i      (io_a_i),
    .io_wd_i     (io_wd_i),
    .io_w_i      (io_w_i),
    .spi_rx_i    (spi_rx),
    .spi_idle_i  (spi_idle),
    .miso_i      (miso_i),
    .wii1_raw_i  (wii1_raw),
    .wii2_raw_i  (wii2_raw),
    .wii1_dec_i  (wii1_dec),
    .wii2_dec_i  (wii2_dec),
    .sample_i    (sample),
    .spi_start_o (spi_start),
    .wii_wr_o    (wii_wr),
    .spi_pins_o  (spi_pins),
    .pd_o        (pd_o),
    .io_rd_o     (io_rd_o)
  );

  ////////////////////////////////////////
  // datapaths
  ////////////////////////////////////////

  spi_engine i_spi (
    .clk50    (clk50),
    .SCKclock (SCKclock),
    .start_i  (spi_start),
    .tx_i     (io_wd_i),
    .miso_i   (miso_i),
    .pins_i   (spi_pins),
    .rx_o     (spi_rx),
    .idle_o   (spi_idle),
    .cs_o     (cs_o),
    .sck_o    (sck_o),
    .mosi_o   (mosi_o),
    .io2_o    (io2_o),
    .io3_o    (io3_o)
  );

  wii_pad_regs i_wii (
    .clk50      (clk50),
    .SCKclock   (SCKclock),
    .wr_i       (wii_wr),
    .wd_i       (io_wd_i),
    .wii1_raw_o (wii1_raw),
    .wii2_raw_o (wii2_raw),
    .wii1_dec_o (wii1_dec),
    .wii2_dec_o (wii2_dec)
  );

  audio_integrator i_audio (
    .clk50    (clk50),
    .SCKclock (SCKclock),
    .audio_i  (audio_i),
    .sample_o (sample)
  );

endmodule

`default_nettype wire

//--- audio_integrator.sv
`default_nettype none

`include "dazzler_config.svh"

module audio_integrator (
  input  logic                 clk50,
  input  logic                 SCKclock,
  input  logic                 audio_i,
  output dazzler_pkg::sample_t sample_o
);

  logic [10:0]          cnt_q;
  dazzler_pkg::sample_t acc_q;
  dazzler_pkg::sample_t weight;
  logic                 last;

  assign last   = (cnt_q == 11'(`DAZ_INT_WINDOW - 1));
  assign weight = audio_i ? 16'(`DAZ_INT_WEIGHT) : -16'(`DAZ_INT_WEIGHT);

  always_ff @(posedge clk50 or posedge SCKclock) begin
    if (SCKclock) begin
      cnt_q    <= '0;
      acc_q    <= '0;
      sample_o <= '0;
    end else begin
      if (last) begin
        sample_o <= acc_q;  // window closes
        cnt_q    <= '0;
        acc_q    <= weight;
      end else begin
        cnt_q <= cnt_q + 11'd1;
        acc_q <= acc_q + weight;
      end
    end
  end

endmodule

`default_nettype wire

//--- wii_pad_regs.sv
`default_nettype none

`include "dazzler_config.svh"

module wii_pad_regs (
  input  logic                  clk50,
  input  logic                  SCKclock,
  input  logic [5:0]            wr_i,
  input  dazzler_pkg::io_word_t wd_i,
  output dazzler_pkg::wii_raw_t wii1_raw_o,
  output dazzler_pkg::wii_raw_t wii2_raw_o,
  output dazzler_pkg::wii_dec_t wii1_dec_o,
  output dazzler_pkg::wii_dec_t wii2_dec_o
);

  dazzler_pkg::wii_raw_t pad_q [2];

  // packed stick and trigger fields live in the low 32 bits
  function automatic dazzler_pkg::wii_dec_t decode(input dazzler_pkg::wii_raw_t raw);
    logic [5:0] lx;
    logic [5:0] ly;
    logic [4:0] rx;
    logic [4:0] ry;
    logic [4:0] lt;
    logic [4:0] rt;
    lx      = raw[5:0];
    rx[4:3] = raw[7:6];
    ly      = raw[13:8];
    rx[2:1] = raw[15:14];
    ry      = raw[20:16];
    lt[4:3] = raw[22:21];
    rx[0]   = raw[23];
    rt      = raw[28:24];
    lt[2:0] = raw[31:29];
    decode = {48'd0,
              3'b000, rt,
              3'b000, lt,
              3'b000, ry,
              3'b000, rx,
              2'b00, ly,
              2'b00, lx};
  endfunction

  always_ff @(posedge clk50 or posedge SCKclock) begin
    if (SCKclock) begin
      pad_q[0] <= `DAZ_WII_RESET;
      pad_q[1] <= `DAZ_WII_RESET;
    end else begin
      // strobes 0..2 for pad 1, 3..5 for pad 2
      for (int k = 0; k < 6; k++) begin
        if (wr_i[k]) begin
          pad_q[k / 3][(k % 3) * 16 +: 16] <= wd_i;
        end
      end
    end
  end

  assign wii1_raw_o = pad_q[0];
  assign wii2_raw_o = pad_q[1];
  assign wii1_dec_o = decode(pad_q[0]);
  assign wii2_dec_o = decode(pad_q[1]);

endmodule

`default_nettype wire

//--- spi_engine.sv
`default_nettype none

`include "dazzler_config.svh"

module spi_engine (
  input  logic                   clk50,
  input  logic                   SCKclock,
  input  logic                   start_i,
  input  dazzler_pkg::io_word_t  tx_i,
  input  logic                   miso_i,
  input  dazzler_pkg::spi_pins_t pins_i,
  output dazzler_pkg::io_word_t  rx_o,
  output logic                   idle_o,
  output logic                   cs_o,
  output logic                   sck_o,
  output logic                   mosi_o,
  output logic                   io2_o,
  output logic                   io3_o
);

  dazzler_pkg::spi_state_t state_q;
  logic [4:0]              cnt_q;    // half-clock count
  dazzler_pkg::io_word_t   shift_q;
  dazzler_pkg::spi_pins_t  merged;

  always_ff @(posedge clk50 or posedge SCKclock) begin
    if (SCKclock) begin
      state_q <= dazzler_pkg::SPI_IDLE;
      cnt_q   <= '0;
      shift_q <= '0;
    end else if (start_i) begin  // restarts a running transfer too
      state_q <= dazzler_pkg::SPI_RUN;
      cnt_q   <= '0;
      shift_q <= tx_i;
    end else if (state_q == dazzler_pkg::SPI_RUN) begin
      if (cnt_q == 5'(`DAZ_SPI_HALF_CLKS - 1)) begin
        state_q <= dazzler_pkg::SPI_IDLE;
        cnt_q   <= '0;
      end else begin
        cnt_q <= cnt_q + 5'd1;
      end
      // sample on the high half of sck, msb first
      if (cnt_q[0]) begin
        shift_q <= {shift_q[14:0], miso_i};
      end
    end
  end

  assign rx_o   = shift_q;
  assign idle_o = (state_q == dazzler_pkg::SPI_IDLE);

  ////////////////////////////////////////
  // pin merge
  ////////////////////////////////////////

  assign merged = pins_i | {1'b0, cnt_q[0], 3'b000, shift_q[15]};

  assign cs_o   = merged[5];
  assign sck_o  = merged[4];
  assign io3_o  = merged[3];
  assign io2_o  = merged[2];
  assign mosi_o = merged[0];

  // engine sck stays low between transfers
  idle_cnt_zero_a : assert property (
    @(posedge clk50) disable iff (SCKclock)
      (state_q == dazzler_pkg::SPI_IDLE) |-> (cnt_q == 5'd0)
  );

endmodule

`default_nettype wire

//--- io_ctrl.sv
`default_nettype none

`include "dazzler_config.svh"

module io_ctrl (
  input  logic                   clk50,
  input  logic                   SCKclock,
  input  dazzler_pkg::io_addr_t  io_a_i,
  input  dazzler_pkg::io_word_t  io_wd_i,
  input  logic                   io_w_i,
  input  dazzler_pkg::io_word_t  spi_rx_i,
  input  logic                   spi_idle_i,
  input  logic                   miso_i,
  input  dazzler_pkg::wii_raw_t  wii1_raw_i,
  input  dazzler_pkg::wii_raw_t  wii2_raw_i,
  input  dazzler_pkg::wii_dec_t  wii1_dec_i,
  input  dazzler_pkg::wii_dec_t  wii2_dec_i,
  input  dazzler_pkg::sample_t   sample_i,
  output logic                   spi_start_o,
  output logic [5:0]             wii_wr_o,
  output dazzler_pkg::spi_pins_t spi_pins_o,
  output logic                   pd_o,
  output dazzler_pkg::io_word_t  io_rd_o
);

  logic                   wr_sysctl;
  logic                   wr_pins;
  dazzler_pkg::io_word_t  sysctl_q;
  dazzler_pkg::spi_pins_t pins_q;
  dazzler_pkg::io_word_t  ticks_q;

  ////////////////////////////////////////
  // write decode
  ////////////////////////////////////////

  assign wr_sysctl   = io_w_i && (io_a_i == `DAZ_ADDR_SYSCTL);
  assign wr_pins     = io_w_i && (io_a_i == `DAZ_ADDR_CSPI);
  assign spi_start_o = io_w_i && (io_a_i == `DAZ_ADDR_SPI_DATA);

  // one strobe per 16-bit controller slice
  assign wii_wr_o[0] = io_w_i && (io_a_i == `DAZ_ADDR_WII1_0);
  assign wii_wr_o[1] = io_w_i && (io_a_i == `DAZ_ADDR_WII1_1);
  assign wii_wr_o[2] = io_w_i && (io_a_i == `DAZ_ADDR_WII1_2);
  assign wii_wr_o[3] = io_w_i && (io_a_i == `DAZ_ADDR_WII2_0);
  assign wii_wr_o[4] = io_w_i && (io_a_i == `DAZ_ADDR_WII2_1);
  assign wii_wr_o[5] = io_w_i && (io_a_i == `DAZ_ADDR_WII2_2);

  ////////////////////////////////////////
  // local registers
  ////////////////////////////////////////

  always_ff @(posedge clk50 or posedge SCKclock) begin
    if (SCKclock) begin
      sysctl_q <= '0;
      pins_q   <= '0;
      ticks_q  <= '0;
    end else begin
      ticks_q <= ticks_q + 16'd1;  // free running and wrapping
      if (wr_sysctl) begin
        sysctl_q <= io_wd_i;
      end
      if (wr_pins) begin
        pins_q <= io_wd_i[5:0];
      end
    end
  end

  assign spi_pins_o = pins_q;
  assign pd_o       = sysctl_q[0];  // external power-down

  ////////////////////////////////////////
  // read-back mux
  ////////////////////////////////////////

  always_comb begin
    case (io_a_i)
      `DAZ_ADDR_WII1_0:     io_rd_o = wii1_raw_i[15:0];
      `DAZ_ADDR_WII1_1:     io_rd_o = wii1_raw_i[31:16];
      `DAZ_ADDR_WII1_2:     io_rd_o = wii1_raw_i[47:32];
      `DAZ_ADDR_WII2_0:     io_rd_o = wii2_raw_i[15:0];
      `DAZ_ADDR_WII2_1:     io_rd_o = wii2_raw_i[31:16];
      `DAZ_ADDR_WII2_2:     io_rd_o = wii2_raw_i[47:32];
      // miso shows up on the undriven pin bit 1
      `DAZ_ADDR_CSPI:       io_rd_o = {10'd0, pins_q} | {14'd0, miso_i, 1'b0};
      `DAZ_ADDR_SYSCTL:     io_rd_o = sysctl_q;
      `DAZ_ADDR_TICKS:      io_rd_o = ticks_q;
      `DAZ_ADDR_SPI_DATA:   io_rd_o = spi_rx_i;
      `DAZ_ADDR_SPI_IDLE:   io_rd_o = {15'd0, spi_idle_i};
      `DAZ_ADDR_SAMPLE:     io_rd_o = sample_i;
      `DAZ_ADDR_WII1_DEC_0: io_rd_o = wii1_dec_i[15:0];   // ly, lx
      `DAZ_ADDR_WII1_DEC_1: io_rd_o = wii1_dec_i[31:16];  // ry, rx
      `DAZ_ADDR_WII1_DEC_2: io_rd_o = wii1_dec_i[47:32];  // rt, lt
      `DAZ_ADDR_WII2_DEC_0: io_rd_o = wii2_dec_i[15:0];
      `DAZ_ADDR_WII2_DEC_1: io_rd_o = wii2_dec_i[31:16];
      `DAZ_ADDR_WII2_DEC_2: io_rd_o = wii2_dec_i[47:32];
      default:              io_rd_o = '0;
    endcase
  end

  // at most one controller slice written per cycle
  wii_wr_onehot_a : assert property (
    @(posedge clk50) disable iff (SCKclock) $onehot0(wii_wr_o)
  );

endmodule

`default_nettype wire

//--- dazzler_pkg.sv
`default_nettype none

package dazzler_pkg;

  // bus side
  typedef logic [11:0] io_addr_t;
  typedef logic [15:0] io_word_t;

  // 5    4    3    2    1          0
  // CS   SCK  IO3  IO2  MISO(n/c)  MOSI
  typedef logic [5:0] spi_pins_t;

  typedef logic [47:0] wii_raw_t;
  typedef logic [95:0] wii_dec_t;  // six bytes used, rt down to lx

  typedef logic signed [15:0] sample_t;

  typedef enum logic {
    SPI_IDLE,
    SPI_RUN
  } spi_state_t;

endpackage

`default_nettype wire

//--- dazzler_config.svh
`ifndef DAZZLER_CONFIG_SVH
`define DAZZLER_CONFIG_SVH

////////////////////////////////////////
// I/O register map, low 12 address bits
////////////////////////////////////////

`define DAZ_ADDR_WII1_0      12'h004
`define DAZ_ADDR_WII1_1      12'h005
`define DAZ_ADDR_WII1_2      12'h006
`define DAZ_ADDR_WII2_0      12'h007
`define DAZ_ADDR_WII2_1      12'h008
`define DAZ_ADDR_WII2_2      12'h009

`define DAZ_ADDR_CSPI        12'h010  // manual spi pins
`define DAZ_ADDR_SYSCTL      12'h014
`define DAZ_ADDR_TICKS       12'h015

`define DAZ_ADDR_SPI_DATA    12'h020  // write starts a transfer
`define DAZ_ADDR_SPI_IDLE    12'h021
`define DAZ_ADDR_SAMPLE      12'h022

// decoded controller fields, two bytes per word
`define DAZ_ADDR_WII1_DEC_0  12'h030
`define DAZ_ADDR_WII1_DEC_1  12'h031
`define DAZ_ADDR_WII1_DEC_2  12'h032
`define DAZ_ADDR_WII2_DEC_0  12'h033
`define DAZ_ADDR_WII2_DEC_1  12'h034
`define DAZ_ADDR_WII2_DEC_2  12'h035

////////////////////////////////////////
// datapath constants
////////////////////////////////////////

`define DAZ_SPI_HALF_CLKS    32       // 16 bits, two half clocks each
`define DAZ_INT_WINDOW       1500
`define DAZ_INT_WEIGHT       21       // floor(32768 / 1500)

`define DAZ_WII_RESET        48'h123456789abc

`endif
